// ==== ks10Mem.f ====
hw/ks10MemPkg.sv
hw/memBusIf.sv
hw/memArray.sv
hw/memStatus.sv
hw/ks10Mem.sv
test/ks10MemTb.sv

// ==== Makefile ====
# Verilator build and run for the KS10 memory controller

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = ks10MemTb
FILELIST  = ks10Mem.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = TEST PASS

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Simulator exit code is ignored, the log decides
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/ks10MemTb.sv ====
`timescale 1ns/10ps

module ks10MemTb;

   import ks10MemPkg::*;

   // Run length in bus cycles
   localparam int NUM_RAND        = 160;
   localparam int DIRECTED_CYCLES = 48;
   localparam int STIM_CYCLES     = 2 * NUM_RAND + DIRECTED_CYCLES;
   localparam int TIMEOUT_CYCLES  = 2 * STIM_CYCLES;

   // IO addresses owned by some other device
   localparam addr_t FOREIGN_IO0 = 22'o100002;
   localparam addr_t FOREIGN_IO1 = 22'o200000;

   logic    clk = 1'b0;
   logic    rst;
   busReq_t busReq;
   busRsp_t busRsp;

   // Response due for the request now on the bus
   busRsp_t expRsp;
   // Same, one cycle later, lined up with busRsp
   busRsp_t expQ;

   // Shadow copy of the installed words
   word_t shadowMem [MEM_WORDS];

   // Shadow MSR bits
   logic shPe;
   logic shPf;
   logic shEe;

   integer seed;
   int     cycleCount;
   int     ackErrors;
   int     dataErrors;
   int     idleErrors;
   addr_t  addrQ [$];
   addr_t  a;
   word_t  d;

   ks10Mem dut0
   (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .busRsp (busRsp)
   );

   // 40 ns bus clock
   always
   begin
      #20 clk = ~clk;
   end

   ////////////////////
   // Model helpers
   ////////////////////

   // MSR as software reads it, KS10 bit 0 at the left
   function automatic word_t msrImage();
      word_t w;
      w     = '0;
      w[3]  = shPe;
      w[4]  = shEe;
      w[12] = shPf;
      return w;
   endfunction

   function automatic word_t randomWord();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[35:0];
   endfunction

   // Random installed address
   function automatic addr_t pickAddr();
      logic [31:0] r;
      r = $random(seed);
      return addr_t'(r[MEM_ABITS-1:0]);
   endfunction

   // Drive point, just after the rising edge
   task automatic nextSlot();
      @(posedge clk);
      #2;
   endtask

   ////////////////////
   // Bus cycles
   ////////////////////

   task automatic writeMem(input addr_t addr, input word_t data);
      nextSlot();
      busReq          = '0;
      busReq.memWrite = 1'b1;
      busReq.addr     = addr;
      busReq.data     = data;
      expRsp          = '0;
      if (int'(addr) < MEM_WORDS)
      begin
         shadowMem[int'(addr)] = data;
         expRsp.ack            = 1'b1;
      end
   endtask

   task automatic readMem(input addr_t addr);
      nextSlot();
      busReq         = '0;
      busReq.memRead = 1'b1;
      busReq.addr    = addr;
      expRsp         = '0;
      // Non-existent memory stays silent
      if (int'(addr) < MEM_WORDS)
      begin
         expRsp.ack  = 1'b1;
         expRsp.data = shadowMem[int'(addr)];
      end
   endtask

   task automatic writeIo(input addr_t addr, input word_t data);
      nextSlot();
      busReq         = '0;
      busReq.ioWrite = 1'b1;
      busReq.addr    = addr;
      busReq.data    = data;
      expRsp         = '0;
      if (addr == MSR_ADDR)
      begin
         // PE plain, PF clear-only, EE is inverted ED
         shPe       = data[3];
         shPf       = shPf & data[12];
         shEe       = ~data[35];
         expRsp.ack = 1'b1;
      end
   endtask

   task automatic readIo(input addr_t addr);
      nextSlot();
      busReq        = '0;
      busReq.ioRead = 1'b1;
      busReq.addr   = addr;
      expRsp        = '0;
      if (addr == MSR_ADDR)
      begin
         expRsp.ack  = 1'b1;
         expRsp.data = msrImage();
      end
   endtask

   task automatic idle();
      nextSlot();
      busReq = '0;
      expRsp = '0;
   endtask

   ////////////////////
   // Checks
   ////////////////////

   always @(posedge clk)
   begin
      if (rst)
         expQ <= '0;
      else
         expQ <= expRsp;
   end

   // Ack exactly one cycle after an owned strobe
   ackCheck : assert property (@(posedge clk) disable iff (rst) busRsp.ack == expQ.ack)
      else
      begin
         ackErrors = ackErrors + 1;
         $display("[FAIL] %0t busRsp.ack expected %0b actual %0b",
                  $time, $sampled(expQ.ack), $sampled(busRsp.ack));
      end

   dataCheck : assert property (@(posedge clk) disable iff (rst) busRsp.data == expQ.data)
      else
      begin
         dataErrors = dataErrors + 1;
         $display("[FAIL] %0t busRsp.data expected %o actual %o",
                  $time, $sampled(expQ.data), $sampled(busRsp.data));
      end

   // Quiet data bus without ack
   idleCheck : assert property (@(posedge clk) disable iff (rst)
      !busRsp.ack |-> busRsp.data == '0)
      else
      begin
         idleErrors = idleErrors + 1;
         $display("[FAIL] %0t busRsp.data expected %o actual %o",
                  $time, 36'o0, $sampled(busRsp.data));
      end

   // Guard against a stuck run
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial
   begin
      seed       = 6;
      rst        = 1'b1;
      busReq     = '0;
      expRsp     = '0;
      cycleCount = 0;
      ackErrors  = 0;
      dataErrors = 0;
      idleErrors = 0;
      // Power-up MSR
      shPe = 1'b0;
      shPf = 1'b1;
      shEe = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      // MSR straight out of reset
      readIo(MSR_ADDR);
      idle();

      // All ones, then all zeros
      writeIo(MSR_ADDR, '1);
      readIo(MSR_ADDR);
      writeIo(MSR_ADDR, '0);
      readIo(MSR_ADDR);
      // PF stays cleared
      d     = '0;
      d[12] = 1'b1;
      writeIo(MSR_ADDR, d);
      readIo(MSR_ADDR);
      idle();

      // Random fill, then read back in the same order
      for (int i = 0; i < NUM_RAND; i++)
      begin
         a = pickAddr();
         addrQ.push_back(a);
         writeMem(a, randomWord());
      end
      foreach (addrQ[i])
         readMem(addrQ[i]);
      idle();

      // Write immediately followed by read of the same word
      a = pickAddr();
      writeMem(a, randomWord());
      readMem(a);
      writeMem(a, randomWord());
      readMem(a);
      writeMem(addr_t'(MEM_WORDS - 1), randomWord());
      readMem(addr_t'(MEM_WORDS - 1));
      idle();

      // Accesses nobody here owns, incl. an alias of an installed word
      a = addrQ[0];
      writeMem(addr_t'(MEM_WORDS + int'(a)), ~shadowMem[int'(a)]);
      readMem(addr_t'(MEM_WORDS + int'(a)));
      readMem(a);
      writeMem(MSR_ADDR, '1);
      readMem('1);
      writeIo(FOREIGN_IO0, '1);
      readIo(FOREIGN_IO1);
      readIo(MSR_ADDR);
      readMem(a);

      // Drain the last response
      idle();
      idle();
      idle();

      $display("Errors: ack %0d, data %0d, idle data %0d, total %0d",
               ackErrors, dataErrors, idleErrors, ackErrors + dataErrors + idleErrors);
      if (ackErrors + dataErrors + idleErrors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== hw/ks10Mem.sv ====
`timescale 1ns/10ps

module ks10Mem
(
   input  logic                 clk,
   input  logic                 rst,
   input  ks10MemPkg::busReq_t  busReq,
   output ks10MemPkg::busRsp_t  busRsp
);

   import ks10MemPkg::*;

   // Array side
   logic                 arrayWe;
   logic                 arrayRe;
   logic [MEM_ABITS-1:0] arrayAddr;
   word_t                arrayWdata;
   word_t                arrayRdata;

   // Status register side
   logic                 msrWe;
   msrWord_t             msrWdata;
   msrState_t            msrState;

   ////////////////////
   // Bus decode and response
   ////////////////////

   memBusIf busIf0
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busRsp     (busRsp),
      .arrayWe    (arrayWe),
      .arrayRe    (arrayRe),
      .arrayAddr  (arrayAddr),
      .arrayWdata (arrayWdata),
      .arrayRdata (arrayRdata),
      .msrWe      (msrWe),
      .msrWdata   (msrWdata),
      .msrState   (msrState)
   );

   // 1K word store
   memArray array0
   (
      .clk   (clk),
      .we    (arrayWe),
      .re    (arrayRe),
      .addr  (arrayAddr),
      .wdata (arrayWdata),
      .rdata (arrayRdata)
   );

   // Memory Status Register at o100000
   memStatus status0
   (
      .clk   (clk),
      .rst   (rst),
      .we    (msrWe),
      .wdata (msrWdata),
      .state (msrState)
   );

endmodule

// ==== hw/memStatus.sv ====
`timescale 1ns/10ps

module memStatus
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   we,
   input  ks10MemPkg::msrWord_t   wdata,
   output ks10MemPkg::msrState_t  state
);

   import ks10MemPkg::*;

   // Bits picked out of the write layout
   logic wrPe;
   logic wrPf;
   logic wrEd;

   ////////////////////
   // Write decode
   ////////////////////

   // Parity error bit, plain read/write
   assign wrPe = wdata.wr.pe;

   // Power fail bit, a zero clears it
   assign wrPf = wdata.wr.pf;

   // ECC disable, stored inverted as ECC enable
   assign wrEd = wdata.wr.ed;

   // EH, UE, RE, FCB and spare fields have no storage

   ////////////////////
   // State bits
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // Power-up, parity clear, power fail flagged, ECC enabled
         state.pe <= 1'b0;
         state.pf <= 1'b1;
         state.ee <= 1'b1;
      end
      else if (we)
      begin
         state.pe <= wrPe;
         // PF can only go low from software
         state.pf <= state.pf & wrPf;
         state.ee <= ~wrEd;
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // Once cleared, PF stays low until the next reset
   assert property (@(posedge clk) disable iff (rst)
      !state.pf |=> !state.pf);

   // No write strobe, no change in any bit
   assert property (@(posedge clk) disable iff (rst)
      !we |=> $stable(state));

endmodule

// ==== hw/memArray.sv ====
`timescale 1ns/10ps

module memArray
(
   input  logic                              clk,
   input  logic                              we,
   input  logic                              re,
   input  logic [ks10MemPkg::MEM_ABITS-1:0]  addr,
   input  ks10MemPkg::word_t                 wdata,
   output ks10MemPkg::word_t                 rdata
);

   import ks10MemPkg::*;

   ////////////////////
   // Storage
   ////////////////////

   // Installed words
   word_t mem [MEM_WORDS];

   // Write at the end of the strobe cycle
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // Registered read, data valid the cycle after the strobe
   // Holds the last word read between strobes
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[addr];
      end
   end

   // Single port, the decoder never issues both
   assert property (@(posedge clk) !(we && re));

endmodule

// ==== hw/memBusIf.sv ====
`timescale 1ns/10ps

module memBusIf
(
   input  logic                              clk,
   input  logic                              rst,
   input  ks10MemPkg::busReq_t               busReq,
   output ks10MemPkg::busRsp_t               busRsp,
   output logic                              arrayWe,
   output logic                              arrayRe,
   output logic [ks10MemPkg::MEM_ABITS-1:0]  arrayAddr,
   output ks10MemPkg::word_t                 arrayWdata,
   input  ks10MemPkg::word_t                 arrayRdata,
   output logic                              msrWe,
   output ks10MemPkg::msrWord_t              msrWdata,
   input  ks10MemPkg::msrState_t             msrState
);

   import ks10MemPkg::*;

   // Address decode results
   logic memHit;
   logic msrHit;
   logic msrRe;

   // Response pipeline, one cycle behind the strobe
   logic ackQ;
   logic readQ;
   logic srcMsrQ;

   // MSR word in read layout
   msrWord_t msrRd;

   ////////////////////
   // Decode
   ////////////////////

   // Installed memory sits at the bottom of the address space
   assign memHit = (busReq.addr < MEM_WORDS);

   // Only one IO address belongs to this controller
   assign msrHit = (busReq.addr == MSR_ADDR);

   // Array strobes
   assign arrayWe    = busReq.memWrite & memHit;
   assign arrayRe    = busReq.memRead & memHit;
   assign arrayAddr  = busReq.addr[36-MEM_ABITS:35];
   assign arrayWdata = busReq.data;

   // MSR strobes, bus word goes straight to the register decode
   assign msrWe    = busReq.ioWrite & msrHit;
   assign msrRe    = busReq.ioRead & msrHit;
   assign msrWdata = busReq.data;

   ////////////////////
   // Response
   ////////////////////

   // Remember ownership, direction and source for the next cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ackQ    <= 1'b0;
         readQ   <= 1'b0;
         srcMsrQ <= 1'b0;
      end
      else
      begin
         ackQ    <= arrayWe | arrayRe | msrWe | msrRe;
         readQ   <= arrayRe | msrRe;
         srcMsrQ <= msrRe;
      end
   end

   // Build MSR read word
   always_comb
   begin
      msrRd       = '0;
      // Unimplemented fields read as zero
      msrRd.rd.pe = msrState.pe;
      msrRd.rd.ee = msrState.ee;
      msrRd.rd.pf = msrState.pf;
   end

   // Data bus is quiet unless a read is being acknowledged
   always_comb
   begin
      busRsp.ack = ackQ;
      if (!ackQ || !readQ)
         busRsp.data = '0;
      else if (srcMsrQ)
         busRsp.data = msrRd;
      else
         busRsp.data = arrayRdata;
   end

   // Backplane arbiter grants one cycle type at a time
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({busReq.memRead, busReq.memWrite, busReq.ioRead, busReq.ioWrite}));

endmodule

// ==== hw/ks10MemPkg.sv ====
package ks10MemPkg;

   ////////////////////
   // Bus words and addresses
   ////////////////////

   // KS10 data word, bit 0 is the MSB
   typedef logic [0:35] word_t;

   // Physical or IO address as carried on the backplane bus
   typedef logic [14:35] addr_t;

   // Installed memory size
   localparam int MEM_WORDS = 1024;

   // Array index width, low bits of the address
   localparam int MEM_ABITS = 10;

   // IO address of the Memory Status Register
   localparam addr_t MSR_ADDR = 22'o100000;

   ////////////////////
   // Bus request and response
   ////////////////////

   // One-cycle strobes, at most one high per cycle
   typedef struct packed {
      logic  memRead;
      logic  memWrite;
      logic  ioRead;
      logic  ioWrite;
      addr_t addr;
      word_t data;
   } busReq_t;

   // Acknowledge pulse with read data in the same cycle
   typedef struct packed {
      logic  ack;
      word_t data;
   } busRsp_t;

   ////////////////////
   // Memory Status Register layouts
   ////////////////////

   // Write layout of the MSR word
   typedef struct packed {
      logic       eh;
      logic       ue;
      logic       re;
      logic       pe;
      logic       ee;
      logic [6:0] spareLh;
      logic       pf;
      logic       zero;
      logic [3:0] spareMid;
      logic [9:0] spareRh;
      logic [6:0] fcb;
      logic       ed;
   } msrWrite_t;

   // Read layout of the MSR word
   typedef struct packed {
      logic        eh;
      logic        ue;
      logic        re;
      logic        pe;
      logic        ee;
      logic [6:0]  ecp;
      logic        pf;
      logic        zero;
      logic [21:0] era;
   } msrRead_t;

   // Same 36 bits, decoded by direction of the access
   typedef union packed {
      msrWrite_t wr;
      msrRead_t  rd;
   } msrWord_t;

   // Stored MSR bits
   typedef struct packed {
      logic pe;
      logic pf;
      logic ee;
   } msrState_t;

endpackage
